//--- src.f
source/boa_pkg.sv
source/boa_mem_align.sv
source/boa_stage_mem.sv
source/boa_dmem.sv
source/boa_mem_top.sv
bench/boa_mem_assert.sv
bench/boa_mem_tb.sv

//--- Bender.yml
package:
  name: boa_mem

sources:
  - files:
      - source/boa_pkg.sv
      - source/boa_mem_align.sv
      - source/boa_stage_mem.sv
      - source/boa_dmem.sv
      - source/boa_mem_top.sv
  - target: test
    files:
      - bench/boa_mem_assert.sv
      - bench/boa_mem_tb.sv

//--- bench/boa_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Directed tests for the MEM stage with its data memory.
module boa_mem_tb import boa_pkg::*; ();

    // Upper bound on records issued by all tests.
    localparam int RECORD_BUDGET     = 200;
    // Worst case per record, stall holds included.
    localparam int CYCLES_PER_RECORD = DMEM_LATENCY + 10;
    localparam int CLK_PERIOD        = 8;
    // Load or store, presentation to q_valid.
    localparam int MEM_LAT           = DMEM_LATENCY + 1;
    // OP-IMM, neither load nor store.
    localparam logic [4:0] OP_ALU    = 5'b00100;

    logic   clk;
    logic   rst;
    logic   clear;
    logic   stall;
    logic   d_valid;
    pc_t    d_pc;
    insn_t  d_insn;
    logic   d_use_rd;
    xlen_t  d_rs1_val;
    xlen_t  d_rs2_val;
    logic   d_trap;
    cause_t d_cause;
    logic   d_ready;
    logic   q_valid;
    pc_t    q_pc;
    insn_t  q_insn;
    logic   q_use_rd;
    xlen_t  q_rd_val;
    logic   q_trap;
    cause_t q_cause;

    // Byte image of every completed store.
    logic [7:0] ref_mem [0:1023];
    xlen_t      rng;
    pc_t        pc_next;

    boa_mem_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog.
    initial begin
        #(RECORD_BUDGET * CYCLES_PER_RECORD * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allotted simulation time.");
        $display("Checks failed");
        $fatal(1);
    end

    function automatic xlen_t xorshift(input xlen_t x);
        xlen_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // I-type or S-type word, rd field x1.
    function automatic insn_t make_insn(input logic [4:0] op, input logic [2:0] f3);
        return {17'b0, f3, 5'd1, op, 2'b11};
    endfunction

    // Index 0..4 to a width code.
    function automatic logic [2:0] width_code(input int k);
        case (k)
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    // Little-endian store into the byte image.
    function automatic void ref_store(input xlen_t addr, input logic [2:0] f3, input xlen_t data);
        int n;
        n = (f3 == F3_B) ? 1 : (f3 == F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[addr[9:0] + i] = data[8*i +: 8];
        end
    endfunction

    // Expected load result from the byte image.
    function automatic xlen_t ref_load(input xlen_t addr, input logic [2:0] f3);
        int a;
        a = addr[9:0];
        case (f3)
            F3_B:    return {{24{ref_mem[a][7]}}, ref_mem[a]};
            F3_BU:   return {24'b0, ref_mem[a]};
            F3_H:    return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            F3_HU:   return {16'b0, ref_mem[a+1], ref_mem[a]};
            default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Put one EX/MEM record on the inputs.
    task automatic drive_record(input logic [4:0] op, input logic [2:0] f3, input xlen_t rs1,
                                input xlen_t rs2, input logic trap, input cause_t cause);
        d_valid   = 1'b1;
        d_pc      = pc_next;
        d_insn    = make_insn(op, f3);
        d_use_rd  = op != RV_OP_STORE;
        d_rs1_val = rs1;
        d_rs2_val = rs2;
        d_trap    = trap;
        d_cause   = cause;
        pc_next   = pc_next + 31'd2;
    endtask

    // Wait for the handshake, counting cycles before it.
    task automatic send(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!d_ready) begin
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        d_valid = 1'b0;
    endtask

    // Returns at the mid-cycle where the MEM/WB record shows.
    task automatic collect(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!(q_valid || q_trap)) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_record(input logic [4:0] op, input logic [2:0] f3, input xlen_t rs1,
                              input xlen_t rs2, input logic trap, input cause_t cause,
                              output int lat);
        int c_send;
        int c_coll;
        @(posedge clk);
        #1;
        drive_record(op, f3, rs1, rs2, trap, cause);
        send(c_send);
        collect(c_coll);
        lat = c_send + c_coll;
    endtask

    task automatic store(input string name, input xlen_t addr, input logic [2:0] f3,
                         input xlen_t data);
        int lat;
        run_record(RV_OP_STORE, f3, addr, data, 1'b0, '0, lat);
        check({name, " q_valid"}, 1, q_valid);
        check({name, " use_rd"}, 0, q_use_rd);
        check({name, " latency"}, MEM_LAT, lat);
        ref_store(addr, f3, data);
    endtask

    task automatic load(input string name, input xlen_t addr, input logic [2:0] f3);
        int lat;
        run_record(RV_OP_LOAD, f3, addr, '0, 1'b0, '0, lat);
        check({name, " q_valid"}, 1, q_valid);
        check({name, " use_rd"}, 1, q_use_rd);
        check({name, " latency"}, MEM_LAT, lat);
        check({name, " data"}, ref_load(addr, f3), q_rd_val);
    endtask

    // Record that must leave as a trap with the given cause.
    task automatic expect_trap(input string name, input logic [4:0] op, input logic [2:0] f3,
                               input xlen_t addr, input logic trap_in, input cause_t cause_in,
                               input cause_t cause_exp);
        int lat;
        rng = xorshift(rng);
        run_record(op, f3, addr, rng, trap_in, cause_in, lat);
        check({name, " q_valid"}, 0, q_valid);
        check({name, " q_trap"}, 1, q_trap);
        check({name, " cause"}, cause_exp, q_cause);
        check({name, " latency"}, 1, lat);
    endtask

    task automatic test_alu();
        int    lat;
        xlen_t v;
        pc_t   pc;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            v   = rng;
            pc  = pc_next;
            run_record(OP_ALU, F3_W, v, ~v, 1'b0, '0, lat);
            check("alu q_valid", 1, q_valid);
            check("alu q_trap", 0, q_trap);
            check("alu rd_val", v, q_rd_val);
            check("alu pc", xlen_t'(pc), xlen_t'(q_pc));
            check("alu insn", make_insn(OP_ALU, F3_W), q_insn);
            check("alu use_rd", 1, q_use_rd);
            check("alu latency", 1, lat);
        end
    endtask

    task automatic test_store_load();
        rng = xorshift(rng);
        store("sw 0x10", 'h10, F3_W, 32'h8bad_f00d);
        store("sw 0x14", 'h14, F3_W, rng);
        store("sb 0x11", 'h11, F3_B, 32'h1234_56c3);
        store("sh 0x16", 'h16, F3_H, 32'habcd_9e71);
        store("sb 0x14", 'h14, F3_B, 32'h0000_007f);
        store("sh 0x12", 'h12, F3_H, 32'h0000_7ffe);
        load("lb 0x11", 'h11, F3_B);
        load("lbu 0x11", 'h11, F3_BU);
        load("lb 0x14", 'h14, F3_B);
        load("lbu 0x17", 'h17, F3_BU);
        load("lh 0x16", 'h16, F3_H);
        load("lhu 0x16", 'h16, F3_HU);
        load("lh 0x12", 'h12, F3_H);
        load("lhu 0x10", 'h10, F3_HU);
        load("lw 0x10", 'h10, F3_W);
        load("lw 0x14", 'h14, F3_W);
    endtask

    task automatic test_misalign();
        store("sw 0x20", 'h20, F3_W, 32'hc001_d00d);
        store("sw 0x24", 'h24, F3_W, 32'h5555_aaaa);
        expect_trap("lh 0x21", RV_OP_LOAD, F3_H, 'h21, 1'b0, '0, CAUSE_LOAD_MISALIGN);
        expect_trap("lhu 0x23", RV_OP_LOAD, F3_HU, 'h23, 1'b0, '0, CAUSE_LOAD_MISALIGN);
        expect_trap("lw 0x22", RV_OP_LOAD, F3_W, 'h22, 1'b0, '0, CAUSE_LOAD_MISALIGN);
        expect_trap("sh 0x21", RV_OP_STORE, F3_H, 'h21, 1'b0, '0, CAUSE_STORE_MISALIGN);
        expect_trap("sw 0x23", RV_OP_STORE, F3_W, 'h23, 1'b0, '0, CAUSE_STORE_MISALIGN);
        load("lw 0x20 after trap", 'h20, F3_W);
        load("lw 0x24 after trap", 'h24, F3_W);
    endtask

    task automatic test_pass_trap();
        store("sw 0x30", 'h30, F3_W, 32'h0bad_cafe);
        // Upstream cause wins, even over a misaligned address.
        expect_trap("trapped sw", RV_OP_STORE, F3_W, 'h30, 1'b1, 4'd2, 4'd2);
        expect_trap("trapped lh", RV_OP_LOAD, F3_H, 'h31, 1'b1, 4'd5, 4'd5);
        load("lw 0x30 after pass", 'h30, F3_W);
    endtask

    task automatic test_stall();
        int c_send;
        int c_coll;
        rng = xorshift(rng);
        store("sw 0x40", 'h40, F3_W, rng);
        rng = xorshift(rng);
        store("sw 0x44", 'h44, F3_W, rng);
        @(posedge clk);
        #1;
        stall = 1'b1;
        drive_record(RV_OP_LOAD, F3_W, 'h40, '0, 1'b0, '0);
        // Response arrives meanwhile and waits in the stage.
        repeat (6) begin
            @(negedge clk);
            check("stall d_ready", 0, d_ready);
            check("stall q_valid", 0, q_valid);
        end
        @(posedge clk);
        #1;
        stall = 1'b0;
        send(c_send);
        collect(c_coll);
        check("stall q_valid", 1, q_valid);
        check("stall data", ref_load('h40, F3_W), q_rd_val);
        // Flush a held load.
        @(posedge clk);
        #1;
        stall = 1'b1;
        drive_record(RV_OP_LOAD, F3_W, 'h44, '0, 1'b0, '0);
        repeat (4) @(negedge clk);
        @(posedge clk);
        #1;
        // Record still offered with its response parked, so only clear keeps it out.
        clear = 1'b1;
        stall = 1'b0;
        @(posedge clk);
        #1;
        clear   = 1'b0;
        d_valid = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check("clear q_valid", 0, q_valid);
            check("clear q_trap", 0, q_trap);
        end
        load("lw 0x44 after clear", 'h44, F3_W);
    endtask

    task automatic test_random();
        xlen_t      r;
        xlen_t      addr;
        logic [2:0] f3;
        // Fill the window so every load has a defined image.
        for (int w = 0; w < 16; w++) begin
            rng = xorshift(rng);
            store("random fill", 'h100 + 4 * w, F3_W, rng);
        end
        for (int i = 0; i < 100; i++) begin
            rng  = xorshift(rng);
            r    = rng;
            f3   = r[31] ? width_code(r[7:0] % 3) : width_code(r[7:0] % 5);
            addr = 'h100 + r[13:8];
            if (f3 == F3_H || f3 == F3_HU) begin
                addr[0] = 1'b0;
            end else if (f3 == F3_W) begin
                addr[1:0] = 2'b00;
            end
            rng = xorshift(rng);
            if (r[31]) begin
                store("random store", addr, f3, rng);
            end else begin
                load("random load", addr, f3);
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        clear     = 1'b0;
        stall     = 1'b0;
        d_valid   = 1'b0;
        d_pc      = '0;
        d_insn    = '0;
        d_use_rd  = 1'b0;
        d_rs1_val = '0;
        d_rs2_val = '0;
        d_trap    = 1'b0;
        d_cause   = '0;
        rng       = 32'h2a30_9a02;
        pc_next   = 31'h40;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_alu();
        test_store_load();
        test_misalign();
        test_pass_trap();
        test_stall();
        test_random();
        repeat (4) @(posedge clk);
        if (dut_i.assert_i.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- bench/boa_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake properties of the MEM stage and its memory bus.
module boa_mem_assert import boa_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       clear,
    input logic       stall,
    input logic       d_ready,
    input logic       q_valid,
    input logic       q_trap,
    input logic       req_valid,
    input logic       req_we,
    input dmem_addr_t req_addr,
    input wmask_t     req_wmask,
    input xlen_t      req_wdata,
    input logic       req_ready,
    input logic       resp_valid
);
    // Failed assertions so far.
    int unsigned fail_count = 0;

    // A waiting request keeps its fields.
    req_hold: assert property (@(posedge clk) disable iff (rst || clear)
        req_valid && !req_ready |=> req_valid && $stable({req_we, req_addr, req_wmask, req_wdata}))
        else begin
            $error("request dropped or changed before acceptance");
            fail_count++;
        end

    // Response only a fixed time after an accepted request.
    resp_after_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(req_valid && req_ready, DMEM_LATENCY))
        else begin
            $error("response without an accepted request");
            fail_count++;
        end

    q_exclusive: assert property (@(posedge clk) disable iff (rst) !(q_valid && q_trap))
        else begin
            $error("q_valid and q_trap high together");
            fail_count++;
        end

    stall_blocks: assert property (@(posedge clk) disable iff (rst) stall |-> !d_ready)
        else begin
            $error("d_ready high under stall");
            fail_count++;
        end

endmodule

bind boa_mem_top boa_mem_assert assert_i (.*);

`default_nettype wire

//--- source/boa_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// MEM stage with its data memory.
module boa_mem_top import boa_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   stall,
    // EX/MEM side.
    input  logic   d_valid,
    input  pc_t    d_pc,
    input  insn_t  d_insn,
    input  logic   d_use_rd,
    input  xlen_t  d_rs1_val,
    input  xlen_t  d_rs2_val,
    input  logic   d_trap,
    input  cause_t d_cause,
    output logic   d_ready,
    // MEM/WB side.
    output logic   q_valid,
    output pc_t    q_pc,
    output insn_t  q_insn,
    output logic   q_use_rd,
    output xlen_t  q_rd_val,
    output logic   q_trap,
    output cause_t q_cause
);
    // Internal memory bus.
    logic       req_valid;
    logic       req_we;
    dmem_addr_t req_addr;
    wmask_t     req_wmask;
    xlen_t      req_wdata;
    logic       req_ready;
    logic       resp_valid;
    xlen_t      resp_rdata;

    boa_stage_mem stage_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .stall      (stall),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_insn     (d_insn),
        .d_use_rd   (d_use_rd),
        .d_rs1_val  (d_rs1_val),
        .d_rs2_val  (d_rs2_val),
        .d_trap     (d_trap),
        .d_cause    (d_cause),
        .d_ready    (d_ready),
        .q_valid    (q_valid),
        .q_pc       (q_pc),
        .q_insn     (q_insn),
        .q_use_rd   (q_use_rd),
        .q_rd_val   (q_rd_val),
        .q_trap     (q_trap),
        .q_cause    (q_cause),
        .req_valid  (req_valid),
        .req_we     (req_we),
        .req_addr   (req_addr),
        .req_wmask  (req_wmask),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    boa_dmem dmem_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_we     (req_we),
        .req_addr   (req_addr),
        .req_wmask  (req_wmask),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

endmodule

`default_nettype wire

//--- source/boa_dmem.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-strobed data RAM with a fixed response latency.
module boa_dmem import boa_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Request from the stage.
    input  logic       req_valid,
    input  logic       req_we,
    input  dmem_addr_t req_addr,
    input  wmask_t     req_wmask,
    input  xlen_t      req_wdata,
    output logic       req_ready,
    // Response strobe and read word.
    output logic       resp_valid,
    output xlen_t      resp_rdata
);
    // Storage.
    xlen_t                 mem [0:2**DMEM_ABITS-1];
    // Cycles left until the response is done.
    logic [DMEM_CBITS-1:0] count;
    // Word read at acceptance.
    xlen_t                 rdata_q;
    logic                  accept;

    assign accept = req_valid && req_ready;

    // Idle only once the countdown has run out.
    assign req_ready  = count == '0;
    // Response in the last counted cycle.
    assign resp_valid = count == DMEM_CBITS'(1);
    assign resp_rdata = rdata_q;

    // Response countdown.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (accept) begin
            count <= DMEM_CBITS'(DMEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Array access on acceptance.
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[req_addr];
            for (int i = 0; i < 4; i++) begin
                // Only strobed lanes change.
                if (req_we && req_wmask[i]) begin
                    mem[req_addr][8*i +: 8] <= req_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/boa_stage_mem.sv
`timescale 1ns/1ps
`default_nettype none

// MEM pipeline stage: data memory access and MEM/WB barrier.
module boa_stage_mem import boa_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Flush the stage.
    input  logic       clear,
    // Hold from the hazard unit.
    input  logic       stall,
    // EX/MEM record.
    input  logic       d_valid,
    input  pc_t        d_pc,
    input  insn_t      d_insn,
    input  logic       d_use_rd,
    input  xlen_t      d_rs1_val,
    input  xlen_t      d_rs2_val,
    input  logic       d_trap,
    input  cause_t     d_cause,
    output logic       d_ready,
    // MEM/WB record.
    output logic       q_valid,
    output pc_t        q_pc,
    output insn_t      q_insn,
    output logic       q_use_rd,
    output xlen_t      q_rd_val,
    output logic       q_trap,
    output cause_t     q_cause,
    // Data memory bus.
    output logic       req_valid,
    output logic       req_we,
    output dmem_addr_t req_addr,
    output wmask_t     req_wmask,
    output xlen_t      req_wdata,
    input  logic       req_ready,
    input  logic       resp_valid,
    input  xlen_t      resp_rdata
);
    logic  is_load;
    logic  is_store;
    logic  misaligned;
    xlen_t load_val;
    // Record raises a misalignment trap here.
    logic  mem_trap;
    // Record still needs a bus access.
    logic  needs_mem;
    // A request for the current record was accepted.
    logic  issued;
    // Response arrived under stall and waits here.
    logic  resp_held;
    xlen_t held_rdata;
    // Response available to finish the record.
    logic  resp_ok;
    // Record moves into the barrier.
    logic  xfer;

    // Decode from the major opcode.
    assign is_load  = d_insn[6:2] == RV_OP_LOAD;
    assign is_store = d_insn[6:2] == RV_OP_STORE;

    boa_mem_align align_i (
        .funct3     (d_insn[14:12]),
        .is_store   (is_store),
        .addr       (d_rs1_val),
        .wdata      (d_rs2_val),
        .rdata      (resp_held ? held_rdata : resp_rdata),
        .word_addr  (req_addr),
        .wmask      (req_wmask),
        .wdata_lane (req_wdata),
        .load_val   (load_val),
        .misaligned (misaligned)
    );

    assign mem_trap  = d_valid && !d_trap && (is_load || is_store) && misaligned;
    assign needs_mem = d_valid && !d_trap && (is_load || is_store) && !misaligned;

    // One request per record, none while flushing.
    assign req_valid = needs_mem && !issued && !clear;
    assign req_we    = is_store;

    assign resp_ok = resp_held || (issued && resp_valid);
    assign d_ready = !stall && (!needs_mem || resp_ok);
    assign xfer    = d_valid && d_ready;

    // Bus progress for the current record.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            issued    <= 1'b0;
            resp_held <= 1'b0;
        end else if (xfer) begin
            issued    <= 1'b0;
            resp_held <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                issued <= 1'b1;
            end
            // Park the response until the stall lifts.
            if (issued && resp_valid) begin
                resp_held <= 1'b1;
            end
        end
    end

    // Held response word.
    always_ff @(posedge clk) begin
        if (issued && resp_valid && !resp_held) begin
            held_rdata <= resp_rdata;
        end
    end

    // Barrier control bits.
    always_ff @(posedge clk) begin
        if (rst || clear || stall) begin
            q_valid <= 1'b0;
            q_trap  <= 1'b0;
        end else begin
            q_valid <= xfer && !d_trap && !mem_trap;
            q_trap  <= xfer && (d_trap || mem_trap);
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        if (xfer) begin
            q_pc     <= d_pc;
            q_insn   <= d_insn;
            q_use_rd <= d_use_rd;
            q_rd_val <= is_load ? load_val : d_rs1_val;
            // Earlier trap keeps its own cause.
            if (d_trap) begin
                q_cause <= d_cause;
            end else begin
                q_cause <= is_store ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/boa_mem_align.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-lane steering for stores and extraction for loads.
module boa_mem_align import boa_pkg::*; (
    // Access width code.
    input  logic [2:0] funct3,
    // Store access; a load otherwise.
    input  logic       is_store,
    // Byte address.
    input  xlen_t      addr,
    // Store data, right-aligned.
    input  xlen_t      wdata,
    // Raw word from the memory.
    input  xlen_t      rdata,
    // Word index for the memory.
    output dmem_addr_t word_addr,
    // Byte strobe, zero for loads.
    output wmask_t     wmask,
    // Store data placed on its lanes.
    output xlen_t      wdata_lane,
    // Extended load result.
    output xlen_t      load_val,
    // Access crosses its natural boundary.
    output logic       misaligned
);
    // Byte offset within the word.
    logic [1:0] offset;
    // Strobe before the store qualifier.
    wmask_t     lane_mask;
    // Response shifted down to the addressed byte.
    xlen_t      shifted;

    assign offset    = addr[1:0];
    assign word_addr = addr[DMEM_ABITS+1:2];
    assign wmask     = is_store ? lane_mask : '0;
    assign shifted   = rdata >> {offset, 3'b000};

    // Store steering and alignment check.
    always_comb begin
        case (funct3)
            F3_B, F3_BU: begin
                // Any byte address is fine.
                lane_mask  = wmask_t'(4'b0001 << offset);
                wdata_lane = {4{wdata[7:0]}};
                misaligned = 1'b0;
            end
            F3_H, F3_HU: begin
                lane_mask  = wmask_t'(4'b0011 << offset);
                wdata_lane = {2{wdata[15:0]}};
                misaligned = offset[0];
            end
            default: begin
                // Word, and unused codes treated alike.
                lane_mask  = 4'b1111;
                wdata_lane = wdata;
                misaligned = offset != 2'b00;
            end
        endcase
    end

    // Load extraction with sign or zero fill.
    always_comb begin
        case (funct3)
            F3_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
            F3_BU:   load_val = {24'b0, shifted[7:0]};
            F3_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
            F3_HU:   load_val = {16'b0, shifted[15:0]};
            default: load_val = rdata;
        endcase
    end

endmodule

`default_nettype wire

//--- source/boa_pkg.sv
`default_nettype none

// Shared types and constants of the memory-access stage.
package boa_pkg;

    // Data word.
    typedef logic [31:0] xlen_t;
    // Instruction address, bit 0 implied.
    typedef logic [31:1] pc_t;
    // Instruction word.
    typedef logic [31:0] insn_t;
    // Trap cause code.
    typedef logic [3:0]  cause_t;
    // Byte write strobe.
    typedef logic [3:0]  wmask_t;

    // Major opcodes, instruction bits 6:2.
    localparam logic [4:0] RV_OP_LOAD  = 5'b00000;
    localparam logic [4:0] RV_OP_STORE = 5'b01000;

    // Access width codes from funct3.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // Trap causes raised by this stage.
    localparam cause_t CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam cause_t CAUSE_STORE_MISALIGN = 4'd6;

    // Data memory geometry and timing.
    localparam int DMEM_ABITS   = 8;
    localparam int DMEM_LATENCY = 2;
    // Width of the response countdown.
    localparam int DMEM_CBITS   = $clog2(DMEM_LATENCY + 1);

    // Word index into the data memory.
    typedef logic [DMEM_ABITS-1:0] dmem_addr_t;

endpackage

`default_nettype wire
